/* vmem_pkg.sv */
// Virtual memory map package with entry layouts, address fields and walk helpers
`default_nettype none

package vmem_pkg;

   // ####################
   // Widths
   // ####################
   localparam int VADDR_W    = 24;
   localparam int PADDR_W    = 23;
   localparam int INDEX_W    = 10;
   localparam int BLOCK_W    = 5;
   localparam int PAGE_W     = 14;
   localparam int SPARE_W    = 8;
   localparam int OFFSET_W   = 9;
   localparam int WB_ADR_W   = 12;
   localparam int WB_DAT_W   = 32;
   localparam int WB_SEL_BIT = 11;                 // Set selects level 2, clear selects level 1

   typedef logic [VADDR_W-1:0] vaddr_t;
   typedef logic [PADDR_W-1:0] paddr_t;
   typedef logic [INDEX_W-1:0] map_index_t;

   // ####################
   // Map entries
   // ####################
   typedef struct packed {
      logic               valid;
      logic [BLOCK_W-1:0] l2_block;
   } l1_entry_t;

   typedef struct packed {
      logic               perm_read;
      logic               perm_write;
      logic [SPARE_W-1:0] spare;
      logic [PAGE_W-1:0]  phys_page;
   } l2_entry_t;                                   // Same layout as the 24-bit map word

   typedef struct packed {
      logic   valid;
      logic   write;
      vaddr_t vaddr;
   } xlate_req_t;

   typedef struct packed {
      logic   valid;
      logic   fault;
      paddr_t paddr;
   } xlate_rsp_t;

   function automatic map_index_t l1_index(input vaddr_t va);
      return va[VADDR_W-1 -: INDEX_W];             // Top ten bits of the address
   endfunction

   function automatic map_index_t l2_index(input logic [BLOCK_W-1:0] block, input vaddr_t va);
      return {block, va[OFFSET_W +: INDEX_W-BLOCK_W]};
   endfunction

   function automatic paddr_t phys_addr(input logic [PAGE_W-1:0] page, input vaddr_t va);
      return {page, va[OFFSET_W-1:0]};
   endfunction

endpackage

`default_nettype wire

/* vmem_dpram.sv */
// Dual-port synchronous map RAM where port A writes win and reads return old data
`timescale 1ns/1ps
`default_nettype none

module vmem_dpram
   import vmem_pkg::*;
#(
   parameter type payload_t = l2_entry_t,
   parameter int  MAP_DEPTH = 1024
)
(
   input  logic       clk_a,
   input  logic       reset,
   input  map_index_t address_a,
   input  map_index_t address_b,
   input  logic       wren_a,
   input  logic       rden_a,
   input  logic       wren_b,
   input  logic       rden_b,
   input  payload_t   data_a,
   input  payload_t   data_b,
   output payload_t   q_a,
   output payload_t   q_b
);

   localparam int AW = $clog2(MAP_DEPTH);

   payload_t mem [0:MAP_DEPTH-1];

   always_ff @(posedge clk_a)
   begin
      if (wren_a)
      begin
         mem[address_a[AW-1:0]] <= data_a;
      end
      else if (wren_b)
      begin
         mem[address_b[AW-1:0]] <= data_b;           // Dropped when port A writes the same cycle
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
         q_b <= '0;
      end
      else
      begin
         if (rden_a)
         begin
            q_a <= mem[address_a[AW-1:0]];           // Sees the contents before this edge
         end
         if (rden_b)
         begin
            q_b <= mem[address_b[AW-1:0]];
         end
      end
   end

endmodule

`default_nettype wire

/* vmem_wb_port.sv */
// Wishbone classic slave giving software port-B access to both map levels
`timescale 1ns/1ps
`default_nettype none

module vmem_wb_port
   import vmem_pkg::*;
(
   input  logic                clk_a,
   input  logic                reset,
   input  logic                cyc,
   input  logic                stb,
   input  logic                we,
   input  logic [WB_ADR_W-1:0] adr,
   input  logic [WB_DAT_W-1:0] dat_w,
   output logic [WB_DAT_W-1:0] dat_r,
   output logic                ack,
   output map_index_t          l1_address,
   output map_index_t          l2_address,
   output logic                l1_wren,
   output logic                l1_rden,
   output logic                l2_wren,
   output logic                l2_rden,
   output l1_entry_t           l1_data,
   output l2_entry_t           l2_data,
   input  l1_entry_t           l1_q,
   input  l2_entry_t           l2_q
);

   localparam int L1_W = $bits(l1_entry_t);
   localparam int L2_W = $bits(l2_entry_t);

   typedef enum logic [1:0] {st_idle, st_wait, st_ack} wb_state_t;

   wb_state_t state;
   logic      start;
   logic      sel_l2;

   assign start  = (state == st_idle) && cyc && stb;   // RAM access happens on this edge only
   assign sel_l2 = adr[WB_SEL_BIT];

   assign l1_address = adr[INDEX_W-1:0];
   assign l2_address = adr[INDEX_W-1:0];

   assign l1_wren = start && we && !sel_l2;
   assign l1_rden = start && !we && !sel_l2;
   assign l2_wren = start && we && sel_l2;
   assign l2_rden = start && !we && sel_l2;

   assign l1_data = dat_w[L1_W-1:0];
   assign l2_data = dat_w[L2_W-1:0];

   // Port B output is stable until the next bus access, so the mux can follow adr
   assign dat_r = sel_l2 ? {{(WB_DAT_W-L2_W){1'b0}}, l2_q} : {{(WB_DAT_W-L1_W){1'b0}}, l1_q};

   assign ack = (state == st_ack);

   // ####################
   // Transfer FSM
   // ####################
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state <= st_idle;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (cyc && stb)
               begin
                  state <= st_wait;                  // Write done or read data registered
               end
            end
            st_wait:
            begin
               state <= (cyc && stb) ? st_ack : st_idle;
            end
            st_ack:
            begin
               state <= st_idle;                     // Forces ack low between transfers
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* vmem_translate.sv */
// Three-stage translator walking the level-1 and level-2 maps through port A
`timescale 1ns/1ps
`default_nettype none

module vmem_translate
   import vmem_pkg::*;
(
   input  logic       clk_a,
   input  logic       reset,
   input  xlate_req_t req,
   output xlate_rsp_t rsp,
   output map_index_t l1_address,
   output map_index_t l2_address,
   output logic       l1_rden,
   output logic       l2_rden,
   input  l1_entry_t  l1_q,
   input  l2_entry_t  l2_q
);

   xlate_req_t s1;                                 // Request beside the level-1 read
   xlate_req_t s2;                                 // Request beside the level-2 read
   logic       s2_l1_valid;
   logic       perm_ok;
   logic       fault;

   // ####################
   // Level-1 lookup
   // ####################
   assign l1_address = l1_index(req.vaddr);
   assign l1_rden    = req.valid;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s1.valid <= 1'b0;
      end
      else
      begin
         s1 <= req;
      end
   end

   // ####################
   // Level-2 lookup
   // ####################
   assign l2_address = l2_index(l1_q.l2_block, s1.vaddr);
   assign l2_rden    = s1.valid;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s2.valid <= 1'b0;
      end
      else
      begin
         s2          <= s1;
         s2_l1_valid <= l1_q.valid;                // Level-1 result rides along for the fault
      end
   end

   // ####################
   // Response
   // ####################
   assign perm_ok = s2.write ? l2_q.perm_write : l2_q.perm_read;
   assign fault   = !s2_l1_valid || !perm_ok;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         rsp.valid <= 1'b0;
         rsp.fault <= 1'b0;
      end
      else
      begin
         rsp.valid <= s2.valid;
         rsp.fault <= s2.valid && fault;
         rsp.paddr <= fault ? '0 : phys_addr(l2_q.phys_page, s2.vaddr);
      end
   end

endmodule

`default_nettype wire

/* vmem_map.sv */
// Virtual address map top level with translator, bus port and both map RAMs
`timescale 1ns/1ps
`default_nettype none

module vmem_map
   import vmem_pkg::*;
#(
   parameter int MAP_DEPTH = 1024
)
(
   input  logic                clk_a,
   input  logic                reset,
   input  xlate_req_t          req,
   output xlate_rsp_t          rsp,
   input  logic                cyc,
   input  logic                stb,
   input  logic                we,
   input  logic [WB_ADR_W-1:0] adr,
   input  logic [WB_DAT_W-1:0] dat_w,
   output logic [WB_DAT_W-1:0] dat_r,
   output logic                ack
);

   map_index_t l1_address_a;
   map_index_t l2_address_a;
   logic       l1_rden_a;
   logic       l2_rden_a;
   l1_entry_t  l1_q_a;
   l2_entry_t  l2_q_a;

   map_index_t l1_address_b;
   map_index_t l2_address_b;
   logic       l1_wren_b;
   logic       l1_rden_b;
   logic       l2_wren_b;
   logic       l2_rden_b;
   l1_entry_t  l1_data_b;
   l2_entry_t  l2_data_b;
   l1_entry_t  l1_q_b;
   l2_entry_t  l2_q_b;

   vmem_translate xlate (
      .clk_a      (clk_a),
      .reset      (reset),
      .req        (req),
      .rsp        (rsp),
      .l1_address (l1_address_a),
      .l2_address (l2_address_a),
      .l1_rden    (l1_rden_a),
      .l2_rden    (l2_rden_a),
      .l1_q       (l1_q_a),
      .l2_q       (l2_q_a)
   );

   vmem_wb_port bus (
      .clk_a      (clk_a),
      .reset      (reset),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .dat_w      (dat_w),
      .dat_r      (dat_r),
      .ack        (ack),
      .l1_address (l1_address_b),
      .l2_address (l2_address_b),
      .l1_wren    (l1_wren_b),
      .l1_rden    (l1_rden_b),
      .l2_wren    (l2_wren_b),
      .l2_rden    (l2_rden_b),
      .l1_data    (l1_data_b),
      .l2_data    (l2_data_b),
      .l1_q       (l1_q_b),
      .l2_q       (l2_q_b)
   );

   // Port A only reads, the maps are loaded through the bus
   vmem_dpram #(.payload_t(l1_entry_t), .MAP_DEPTH(MAP_DEPTH)) map_l1 (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (l1_address_a),
      .address_b (l1_address_b),
      .wren_a    (1'b0),
      .rden_a    (l1_rden_a),
      .wren_b    (l1_wren_b),
      .rden_b    (l1_rden_b),
      .data_a    ('0),
      .data_b    (l1_data_b),
      .q_a       (l1_q_a),
      .q_b       (l1_q_b)
   );

   vmem_dpram #(.payload_t(l2_entry_t), .MAP_DEPTH(MAP_DEPTH)) map_l2 (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (l2_address_a),
      .address_b (l2_address_b),
      .wren_a    (1'b0),
      .rden_a    (l2_rden_a),
      .wren_b    (l2_wren_b),
      .rden_b    (l2_rden_b),
      .data_a    ('0),
      .data_b    (l2_data_b),
      .q_a       (l2_q_a),
      .q_b       (l2_q_b)
   );

endmodule

`default_nettype wire

/* vmem_checker.sv */
// Scoreboard predicting translations and bus reads of the map from shadow copies
`timescale 1ns/1ps
`default_nettype none

module vmem_checker
   import vmem_pkg::*;
#(
   parameter int NAME_W = 96
)
(
   input  logic                clk_a,
   input  logic                reset,
   input  xlate_req_t          req,
   input  xlate_rsp_t          rsp,
   input  logic                cyc,
   input  logic                stb,
   input  logic                we,
   input  logic [WB_ADR_W-1:0] adr,
   input  logic [WB_DAT_W-1:0] dat_w,
   input  logic [WB_DAT_W-1:0] dat_r,
   input  logic                ack,
   input  logic [NAME_W-1:0]   test_name,
   output int                  pass_count,
   output int                  fail_count,
   output int                  pending
);

   typedef struct packed {
      logic              valid;
      logic              fault;
      paddr_t            paddr;
      logic [NAME_W-1:0] name;
   } expect_t;

   logic [5:0]  shadow_l1 [0:1023];
   logic [23:0] shadow_l2 [0:1023];
   expect_t     pipe [0:2];                        // Index 2 is due on this edge
   logic [31:0] expected_read;

   function automatic expect_t predict(input xlate_req_t r, input logic [NAME_W-1:0] name);
      expect_t     e;
      logic [5:0]  l1e;
      logic [23:0] l2e;
      logic        allowed;
      e = '0;
      if (r.valid)
      begin
         e.valid = 1'b1;
         e.name  = name;
         l1e     = shadow_l1[r.vaddr[23:14]];
         l2e     = shadow_l2[{l1e[4:0], r.vaddr[13:9]}];
         allowed = r.write ? l2e[22] : l2e[23];
         if (!l1e[5] || !allowed)
         begin
            e.fault = 1'b1;                        // Faulting responses carry a zero address
         end
         else
         begin
            e.paddr = {l2e[13:0], r.vaddr[8:0]};
         end
      end
      return e;
   endfunction

   always @(posedge clk_a)
   begin
      if (reset)
      begin
         pipe[0]    = '0;
         pipe[1]    = '0;
         pipe[2]    = '0;
         pass_count = 0;
         fail_count = 0;
      end
      else
      begin
         // ####################
         // Translation responses
         // ####################
         if (pipe[2].valid)
         begin
            if (rsp !== {1'b1, pipe[2].fault, pipe[2].paddr})
            begin
               $display("Mismatch %0s expected %h actual %h", pipe[2].name,
                        {1'b1, pipe[2].fault, pipe[2].paddr}, rsp);
               fail_count++;
            end
            else
            begin
               $display("ok %0s fault %0d paddr %h", pipe[2].name, rsp.fault, rsp.paddr);
               pass_count++;
            end
         end
         else if (rsp.valid !== 1'b0)
         begin
            $display("Response valid with no translation request in flight");
            fail_count++;
         end

         // ####################
         // Bus transfers
         // ####################
         if (ack)
         begin
            if (!(cyc && stb))
            begin
               $display("Acknowledge seen with no bus transfer active");
               fail_count++;
            end
            else if (we)
            begin
               if (adr[WB_SEL_BIT])
               begin
                  shadow_l2[adr[INDEX_W-1:0]] = dat_w[23:0];
               end
               else
               begin
                  shadow_l1[adr[INDEX_W-1:0]] = dat_w[5:0];
               end
               $display("done %0s write at %h", test_name, adr);
            end
            else
            begin
               expected_read = adr[WB_SEL_BIT] ? {8'h00, shadow_l2[adr[INDEX_W-1:0]]}
                                               : {26'd0, shadow_l1[adr[INDEX_W-1:0]]};
               if (dat_r !== expected_read)
               begin
                  $display("Mismatch %0s expected %h actual %h", test_name, expected_read, dat_r);
                  fail_count++;
               end
               else
               begin
                  $display("ok %0s read %h", test_name, dat_r);
                  pass_count++;
               end
            end
         end

         pipe[2] = pipe[1];
         pipe[1] = pipe[0];
         pipe[0] = predict(req, test_name);        // Shadow as it stands when the request enters
      end
      pending = int'(pipe[0].valid) + int'(pipe[1].valid) + int'(pipe[2].valid);
   end

endmodule

`default_nettype wire

/* vmem_map_sva.sv */
// Assertions on bus acknowledge and translation response timing of the map top level
`timescale 1ns/1ps
`default_nettype none

module vmem_map_sva
   import vmem_pkg::*;
(
   input logic       clk_a,
   input logic       reset,
   input xlate_req_t req,
   input xlate_rsp_t rsp,
   input logic       cyc,
   input logic       stb,
   input logic       ack
);

   ack_single: assert property (@(posedge clk_a) disable iff (reset) ack |=> !ack)
      else $error("ack stayed high for two cycles");

   ack_in_transfer: assert property (@(posedge clk_a) disable iff (reset) ack |-> (cyc && stb))
      else $error("ack high outside a bus transfer");

   // Checked once the pipeline has run three edges out of reset
   rsp_latency: assert property (@(posedge clk_a) disable iff (reset)
      $past(!reset, 3) |-> (rsp.valid == $past(req.valid, 3)))
      else $error("response valid does not follow request valid by three cycles");

   quiet_in_reset: assert property (@(posedge clk_a) reset |=> (!ack && !rsp.valid))
      else $error("ack or response valid high during reset");

endmodule

bind vmem_map vmem_map_sva sva (
   .clk_a (clk_a),
   .reset (reset),
   .req   (req),
   .rsp   (rsp),
   .cyc   (cyc),
   .stb   (stb),
   .ack   (ack)
);

`default_nettype wire

/* tb_vmem_map.sv */
// Testbench top for the virtual address map that applies a table of bus and translation steps
`timescale 1ns/1ps
`default_nettype none

module tb_vmem_map
   import vmem_pkg::*;
();

   localparam int NAME_W   = 8*12;
   localparam int MAX_WAIT = 20;

   typedef enum logic [1:0] {k_write, k_read, k_xlate} step_kind_t;

   typedef struct packed {
      step_kind_t        kind;
      logic [NAME_W-1:0] name;
      logic [23:0]       addr;
      logic [31:0]       data;                     // Bit 0 is the access kind for translations
   } step_t;

   logic                clk_a;
   logic                reset;
   xlate_req_t          req;
   xlate_rsp_t          rsp;
   logic                cyc;
   logic                stb;
   logic                we;
   logic [WB_ADR_W-1:0] adr;
   logic [WB_DAT_W-1:0] dat_w;
   logic [WB_DAT_W-1:0] dat_r;
   logic                ack;
   logic [NAME_W-1:0]   test_name;
   int                  pass_count;
   int                  fail_count;
   int                  pending;
   logic [31:0]         lfsr;
   logic                timed_out;
   step_t               steps [$];

   vmem_map #(.MAP_DEPTH(1024)) UUT (
      .clk_a (clk_a), .reset (reset), .req (req), .rsp (rsp),
      .cyc (cyc), .stb (stb), .we (we), .adr (adr),
      .dat_w (dat_w), .dat_r (dat_r), .ack (ack)
   );

   vmem_checker #(.NAME_W(NAME_W)) check (
      .clk_a (clk_a), .reset (reset), .req (req), .rsp (rsp),
      .cyc (cyc), .stb (stb), .we (we), .adr (adr), .dat_w (dat_w),
      .dat_r (dat_r), .ack (ack), .test_name (test_name),
      .pass_count (pass_count), .fail_count (fail_count), .pending (pending)
   );

   always #4 clk_a = ~clk_a;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [23:0] take_bits(input int n);
      logic [23:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);                  // One step for every bit taken
         v    = {v[22:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic add_step(input step_kind_t kind, input logic [NAME_W-1:0] name,
                           input logic [23:0] addr, input logic [31:0] data);
      step_t s;
      s.kind = kind;
      s.name = name;
      s.addr = addr;
      s.data = data;
      steps.push_back(s);
   endtask

   // Random pages stay inside the four loaded level-1 entries and two level-2 slots each
   task automatic add_random(input int n);
      logic [23:0] l1;
      logic [23:0] sub;
      logic [23:0] off;
      logic [23:0] wr;
      for (int i = 0; i < n; i++)
      begin
         l1  = take_bits(2);
         sub = take_bits(1);
         off = take_bits(9);
         wr  = take_bits(1);
         add_step(k_xlate, "rand_xlate", {8'h00, l1[1:0], 4'h0, sub[0], off[8:0]}, {31'd0, wr[0]});
      end
   endtask

   task automatic bus_transfer(input step_t s);
      int waited;
      @(negedge clk_a);
      req       = '0;
      test_name = s.name;
      cyc       = 1'b1;
      stb       = 1'b1;
      we        = (s.kind == k_write);
      adr       = s.addr[WB_ADR_W-1:0];
      dat_w     = s.data;
      waited    = 0;
      while (!ack && waited < MAX_WAIT)
      begin
         @(negedge clk_a);
         waited++;
      end
      if (!ack)
      begin
         $display("Timeout: no ack for bus transfer %0s", s.name);
         timed_out = 1'b1;
      end
      @(negedge clk_a);                            // Hold until the edge that samples ack has passed
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic issue_translation(input step_t s);
      @(negedge clk_a);
      test_name = s.name;
      req.valid = 1'b1;
      req.write = s.data[0];
      req.vaddr = s.addr;
   endtask

   // ####################
   // Stimulus table
   // ####################
   task automatic build_table();
      add_step(k_write, "l1_blk3_0",   24'h000, 32'h0000_0023);
      add_step(k_write, "l1_blk7_1",   24'h001, 32'h0000_0027);
      add_step(k_write, "l1_inval_2",  24'h002, 32'hffff_ff05);
      add_step(k_write, "l1_blk3_3",   24'h003, 32'h0000_0023);
      add_step(k_write, "l2_rw_060",   24'h860, 32'h00c0_1234);
      add_step(k_write, "l2_ro_061",   24'h861, 32'h0080_0abc);
      add_step(k_write, "l2_rw_0e0",   24'h8e0, 32'habd6_bfff);
      add_step(k_write, "l2_wo_0e1",   24'h8e1, 32'h0040_0001);
      add_step(k_write, "l2_idx0",     24'h800, 32'h0012_3456);
      add_step(k_read,  "rd_l1_0",     24'h000, 32'h0);
      add_step(k_read,  "rd_l2_0",     24'h800, 32'h0);
      add_step(k_read,  "rd_l1_2",     24'h002, 32'h0);
      add_step(k_read,  "rd_l2_0e0",   24'h8e0, 32'h0);
      add_step(k_xlate, "xl_rd_ok",    24'h0001a5, 32'h0);
      add_step(k_xlate, "xl_l1_inval", 24'h008010, 32'h0);
      add_step(k_xlate, "xl_wr_noprm", 24'h000233, 32'h1);
      add_step(k_xlate, "xl_wr_ok",    24'h0040ff, 32'h1);
      add_step(k_xlate, "xl_rd_noprm", 24'h004201, 32'h0);
      add_step(k_xlate, "xl_rd_blk3",  24'h00c1ff, 32'h0);
      add_random(12);
      add_step(k_write, "l2_rw_061",   24'h861, 32'h00c0_2222);
      add_step(k_xlate, "xl_wr_new",   24'h000233, 32'h1);
      add_step(k_write, "l1_fix_2",    24'h002, 32'h0000_0027);
      add_step(k_xlate, "xl_l1_new",   24'h008010, 32'h0);
      add_random(8);
      add_step(k_read,  "rd_l2_061",   24'h861, 32'h0);
   endtask

   initial
   begin
      int waited;
      clk_a     = 1'b0;
      reset     = 1'b1;
      req       = '0;
      cyc       = 1'b0;
      stb       = 1'b0;
      we        = 1'b0;
      adr       = '0;
      dat_w     = '0;
      test_name = '0;
      timed_out = 1'b0;
      lfsr      = 32'hc807_2c01;
      build_table();
      repeat (2) @(negedge clk_a);
      reset = 1'b0;
      for (int i = 0; i < steps.size() && !timed_out; i++)
      begin
         if (steps[i].kind == k_xlate)
         begin
            issue_translation(steps[i]);
         end
         else
         begin
            bus_transfer(steps[i]);
         end
      end
      @(negedge clk_a);
      req    = '0;
      waited = 0;
      while (pending != 0 && waited < MAX_WAIT)
      begin
         @(negedge clk_a);
         waited++;
      end
      if (pending != 0)
      begin
         $display("Timeout: translation responses still outstanding");
         timed_out = 1'b1;
      end
      $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0 && !timed_out)
      begin
         $display("TB PASSED");
      end
      else
      begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
vmem_pkg.sv
vmem_dpram.sv
vmem_wb_port.sv
vmem_translate.sv
vmem_map.sv
vmem_checker.sv
vmem_map_sva.sv
tb_vmem_map.sv

/* run_sim.sh */
#!/bin/sh
# Build the map testbench with Verilator and run it, failing on any error
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module tb_vmem_map -f sources.f -o sim_vmem_map
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_vmem_map > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
   exit 1
fi
exit 0
